// File: source/scalar_types_pkg.sv
// Widths and depths of the scalar unit live here only; change them together with the ISA layout
package scalar_types_pkg;

	////////////////////////////////////////
	// Widths
	////////////////////////////////////////

	// Register value
	localparam int DATA_WIDTH = 32;

	// Register number
	localparam int REG_INDEX_WIDTH = 5;

	// Instruction address
	localparam int ADDRESS_WIDTH = 8;

	// Immediate field of an instruction
	localparam int IMM_WIDTH = 16;

	////////////////////////////////////////
	// Depths
	////////////////////////////////////////

	localparam int NUM_REGS = 32;
	localparam int INSTR_DEPTH = 256;

	////////////////////////////////////////
	// Value types
	////////////////////////////////////////

	typedef logic [DATA_WIDTH-1:0] data_t;
	typedef logic [REG_INDEX_WIDTH-1:0] reg_index_t;
	typedef logic [ADDRESS_WIDTH-1:0] address_t;

	// Two's complement, sign-extended on decode
	typedef logic signed [IMM_WIDTH-1:0] imm_t;

endpackage

// File: source/scalar_isa_pkg.sv
// Opcode values 10 to 15 are unused and behave as op_nop; the instruction word is 35 bits
package scalar_isa_pkg;

	////////////////////////////////////////
	// Opcodes
	////////////////////////////////////////

	typedef enum logic [3:0] {
		op_nop,
		op_add,
		op_sub,
		op_and,
		op_or,
		op_xor,
		op_shl,
		op_shr,
		op_ldi,
		op_end
	} opcode_t;

	////////////////////////////////////////
	// Instruction word
	////////////////////////////////////////

	// Most significant field first
	typedef struct packed {
		opcode_t op;
		scalar_types_pkg::reg_index_t dst;
		scalar_types_pkg::reg_index_t src1;
		scalar_types_pkg::reg_index_t src2;
		scalar_types_pkg::imm_t imm;
	} instr_t;

	////////////////////////////////////////
	// Stage payloads
	////////////////////////////////////////

	// Decode stage, immediate already widened
	typedef struct packed {
		logic valid;
		opcode_t op;
		scalar_types_pkg::reg_index_t dst;
		scalar_types_pkg::reg_index_t src1;
		scalar_types_pkg::reg_index_t src2;
		scalar_types_pkg::data_t imm;
	} decoded_t;

	// Write-back to the register file
	typedef struct packed {
		logic valid;
		scalar_types_pkg::reg_index_t dst;
		scalar_types_pkg::data_t data;
	} result_t;

	typedef struct packed {
		logic zero;
		logic negative;
	} status_t;

	// Instruction store request
	typedef struct packed {
		scalar_types_pkg::address_t address;
		instr_t instr;
	} store_t;

endpackage

// File: source/instr_mem.sv
// Stores only while the pipeline is not fetching; the fetch output holds between requests
`timescale 1ns/100ps

module instr_mem (
	input logic clock,
	input logic reset,
	input logic store_req,
	input scalar_isa_pkg::store_t store,
	output logic store_ack,
	input logic fetch_req,
	input scalar_types_pkg::address_t fetch_address,
	output scalar_isa_pkg::instr_t fetch_instr
);

	scalar_isa_pkg::instr_t mem [scalar_types_pkg::INSTR_DEPTH];

	////////////////////////////////////////
	// Store port
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (store_req) begin
			mem[store.address] <= store.instr;
		end
	end

	// Acknowledge one cycle after the request
	always_ff @(posedge clock) begin
		if (reset) begin
			store_ack <= 1'b0;
		end else begin
			store_ack <= store_req;
		end
	end

	////////////////////////////////////////
	// Fetch port
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (fetch_req) begin
			fetch_instr <= mem[fetch_address];
		end
	end

endmodule

// File: source/scalar_decode.sv
// In-order fetch from address 0 after reset; fetching stops for good once op_end is decoded
`timescale 1ns/100ps

module scalar_decode (
	input logic clock,
	input logic reset,
	input logic run,
	output logic fetch_req,
	output scalar_types_pkg::address_t fetch_address,
	input scalar_isa_pkg::instr_t fetch_instr,
	output scalar_isa_pkg::decoded_t decoded
);

	scalar_types_pkg::address_t pc;
	logic fetch_valid;
	logic stopped;
	logic end_seen;
	scalar_isa_pkg::decoded_t decoded_next;

	////////////////////////////////////////
	// Fetch control
	////////////////////////////////////////

	// op_end sitting on the fetch output blocks the next request
	assign end_seen = fetch_valid && (fetch_instr.op == scalar_isa_pkg::op_end);
	assign fetch_req = run && !stopped && !end_seen;
	assign fetch_address = pc;

	always_ff @(posedge clock) begin
		if (reset) begin
			pc <= '0;
		end else if (fetch_req) begin
			pc <= pc + 1'b1;
		end
	end

	// Marks the word on fetch_instr, held while run is low
	always_ff @(posedge clock) begin
		if (reset) begin
			fetch_valid <= 1'b0;
		end else if (run) begin
			fetch_valid <= fetch_req;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			stopped <= 1'b0;
		end else if (run && end_seen) begin
			stopped <= 1'b1;
		end
	end

	////////////////////////////////////////
	// Decode
	////////////////////////////////////////

	always_comb begin
		decoded_next.valid = fetch_valid && !stopped;
		decoded_next.op = fetch_instr.op;
		decoded_next.dst = fetch_instr.dst;
		decoded_next.src1 = fetch_instr.src1;
		decoded_next.src2 = fetch_instr.src2;
		// Sign extension of the immediate
		decoded_next.imm = {
			{(scalar_types_pkg::DATA_WIDTH - scalar_types_pkg::IMM_WIDTH)
				{fetch_instr.imm[scalar_types_pkg::IMM_WIDTH-1]}},
			fetch_instr.imm};
	end

	// Pipeline register
	always_ff @(posedge clock) begin
		if (reset) begin
			decoded <= '0;
		end else if (run) begin
			decoded <= decoded_next;
		end
	end

endmodule

// File: source/register_file.sv
// All registers are general purpose and cleared by reset; same-cycle writes bypass to reads
`timescale 1ns/100ps

module register_file (
	input logic clock,
	input logic reset,
	input scalar_isa_pkg::result_t write,
	input scalar_types_pkg::reg_index_t read_index1,
	input scalar_types_pkg::reg_index_t read_index2,
	output scalar_types_pkg::data_t read_data1,
	output scalar_types_pkg::data_t read_data2
);

	scalar_types_pkg::data_t regs [scalar_types_pkg::NUM_REGS];

	////////////////////////////////////////
	// Write port
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < scalar_types_pkg::NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (write.valid) begin
			regs[write.dst] <= write.data;
		end
	end

	////////////////////////////////////////
	// Read ports
	////////////////////////////////////////

	// Write-first, covers back-to-back dependencies
	assign read_data1 = (write.valid && (write.dst == read_index1)) ?
		write.data : regs[read_index1];
	assign read_data2 = (write.valid && (write.dst == read_index2)) ?
		write.data : regs[read_index2];

endmodule

// File: source/scalar_execute.sv
// Operands are read combinationally in this stage; shifts use only the low 5 bits of src2
`timescale 1ns/100ps

module scalar_execute (
	input logic clock,
	input logic reset,
	input logic run,
	input scalar_isa_pkg::decoded_t decoded,
	output scalar_types_pkg::reg_index_t read_index1,
	output scalar_types_pkg::reg_index_t read_index2,
	input scalar_types_pkg::data_t read_data1,
	input scalar_types_pkg::data_t read_data2,
	output scalar_isa_pkg::result_t executed,
	output logic end_mark
);

	scalar_types_pkg::data_t alu_out;
	logic writes;
	logic [4:0] shamt;
	scalar_isa_pkg::result_t executed_next;

	////////////////////////////////////////
	// Operand read
	////////////////////////////////////////

	assign read_index1 = decoded.src1;
	assign read_index2 = decoded.src2;

	assign shamt = read_data2[4:0];

	////////////////////////////////////////
	// ALU
	////////////////////////////////////////

	always_comb begin
		alu_out = '0;
		writes = 1'b1;
		case (decoded.op)
			scalar_isa_pkg::op_add: alu_out = read_data1 + read_data2;
			scalar_isa_pkg::op_sub: alu_out = read_data1 - read_data2;
			scalar_isa_pkg::op_and: alu_out = read_data1 & read_data2;
			scalar_isa_pkg::op_or: alu_out = read_data1 | read_data2;
			scalar_isa_pkg::op_xor: alu_out = read_data1 ^ read_data2;
			scalar_isa_pkg::op_shl: alu_out = read_data1 << shamt;
			scalar_isa_pkg::op_shr: alu_out = read_data1 >> shamt;
			scalar_isa_pkg::op_ldi: alu_out = decoded.imm;
			// op_nop, op_end and unused codes
			default: writes = 1'b0;
		endcase
	end

	always_comb begin
		executed_next.valid = decoded.valid && writes;
		executed_next.dst = decoded.dst;
		executed_next.data = alu_out;
	end

	////////////////////////////////////////
	// Pipeline register
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			executed <= '0;
			end_mark <= 1'b0;
		end else if (run) begin
			executed <= executed_next;
			// End marker travels alongside, never as a write
			end_mark <= decoded.valid && (decoded.op == scalar_isa_pkg::op_end);
		end
	end

endmodule

// File: source/scalar_result.sv
// Write-back is suppressed while run is low; term stays set until reset
`timescale 1ns/100ps

module scalar_result (
	input logic clock,
	input logic reset,
	input logic run,
	input scalar_isa_pkg::result_t executed,
	input logic end_mark,
	output scalar_isa_pkg::result_t write,
	output scalar_isa_pkg::status_t status,
	output logic term
);

	logic term_held;

	////////////////////////////////////////
	// Write-back
	////////////////////////////////////////

	always_comb begin
		write = executed;
		write.valid = executed.valid && run;
	end

	// Flags of the last written value
	always_ff @(posedge clock) begin
		if (reset) begin
			status <= '0;
		end else if (write.valid) begin
			status.zero <= (write.data == '0);
			status.negative <= write.data[scalar_types_pkg::DATA_WIDTH-1];
		end
	end

	////////////////////////////////////////
	// Termination
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			term_held <= 1'b0;
		end else if (end_mark) begin
			term_held <= 1'b1;
		end
	end

	// Visible as soon as the marker leaves execute
	assign term = term_held || end_mark;

endmodule

// File: source/scalar_unit.sv
// Program must be stored with run low; execution starts at address 0 when run goes high
`timescale 1ns/100ps

module scalar_unit (
	input logic clock,
	input logic reset,
	input logic run,
	input logic store_req,
	input scalar_isa_pkg::store_t store,
	output logic store_ack,
	output scalar_isa_pkg::result_t result,
	output scalar_isa_pkg::status_t status,
	output logic term
);

	logic fetch_req;
	scalar_types_pkg::address_t fetch_address;
	scalar_isa_pkg::instr_t fetch_instr;
	scalar_isa_pkg::decoded_t decoded;
	scalar_types_pkg::reg_index_t read_index1;
	scalar_types_pkg::reg_index_t read_index2;
	scalar_types_pkg::data_t read_data1;
	scalar_types_pkg::data_t read_data2;
	scalar_isa_pkg::result_t executed;
	logic end_mark;

	////////////////////////////////////////
	// Fetch and decode
	////////////////////////////////////////

	instr_mem imem (
		.clock(clock),
		.reset(reset),
		.store_req(store_req),
		.store(store),
		.store_ack(store_ack),
		.fetch_req(fetch_req),
		.fetch_address(fetch_address),
		.fetch_instr(fetch_instr)
	);

	scalar_decode decode (
		.clock(clock),
		.reset(reset),
		.run(run),
		.fetch_req(fetch_req),
		.fetch_address(fetch_address),
		.fetch_instr(fetch_instr),
		.decoded(decoded)
	);

	////////////////////////////////////////
	// Execute and write-back
	////////////////////////////////////////

	scalar_execute execute (
		.clock(clock),
		.reset(reset),
		.run(run),
		.decoded(decoded),
		.read_index1(read_index1),
		.read_index2(read_index2),
		.read_data1(read_data1),
		.read_data2(read_data2),
		.executed(executed),
		.end_mark(end_mark)
	);

	// Write port fed by the gated result
	register_file regfile (
		.clock(clock),
		.reset(reset),
		.write(result),
		.read_index1(read_index1),
		.read_index2(read_index2),
		.read_data1(read_data1),
		.read_data2(read_data2)
	);

	scalar_result result_stage (
		.clock(clock),
		.reset(reset),
		.run(run),
		.executed(executed),
		.end_mark(end_mark),
		.write(result),
		.status(status),
		.term(term)
	);

endmodule

// File: sim/scalar_unit_properties.sv
// Port protocol checks only; result values are compared by the testbench
`timescale 1ns/100ps

module scalar_unit_properties (
	input logic clock,
	input logic reset,
	input logic run,
	input logic store_req,
	input logic store_ack,
	input scalar_isa_pkg::result_t result,
	input logic term
);

	// Acknowledge exactly one cycle after the request
	ack_after_req: assert property (@(posedge clock) disable iff (reset)
		store_req |=> store_ack)
		else $error("store_ack missing one cycle after store_req");

	ack_only_after_req: assert property (@(posedge clock) disable iff (reset)
		store_ack |-> $past(store_req))
		else $error("store_ack without store_req one cycle before");

	no_result_when_idle: assert property (@(posedge clock)
		(!run || reset) |-> !result.valid)
		else $error("result.valid high while run is low or reset is high");

	// Termination is held until reset
	term_held: assert property (@(posedge clock) disable iff (reset)
		term |=> term)
		else $error("term fell without reset");

	no_result_after_term: assert property (@(posedge clock) disable iff (reset)
		term |-> !result.valid)
		else $error("result.valid high after term");

endmodule

bind scalar_unit scalar_unit_properties properties (
	.clock(clock),
	.reset(reset),
	.run(run),
	.store_req(store_req),
	.store_ack(store_ack),
	.result(result),
	.term(term)
);

// File: sim/scalar_unit_tb.sv
// Reads sim/scalar_stim.txt relative to the project root; the program is stored once, run twice
`timescale 1ns/100ps

module scalar_unit_tb;

	localparam string STIM_FILE = "sim/scalar_stim.txt";
	localparam int RANDOM_SEED = 32'hb230;
	localparam int RESET_CYCLES = 16;
	localparam int STORE_TIMEOUT = 8;
	localparam int RUN_TIMEOUT = 2000;
	localparam int TAIL_CYCLES = 20;

	logic clock;
	logic reset;
	logic run;
	logic store_req;
	scalar_isa_pkg::store_t store;
	logic store_ack;
	scalar_isa_pkg::result_t result;
	scalar_isa_pkg::status_t status;
	logic term;

	scalar_types_pkg::address_t prog_addr[$];
	scalar_isa_pkg::instr_t prog_word[$];
	scalar_types_pkg::reg_index_t exp_dst[$];
	scalar_types_pkg::data_t exp_data[$];
	scalar_isa_pkg::instr_t model_mem[scalar_types_pkg::INSTR_DEPTH];
	scalar_types_pkg::data_t model_regs[scalar_types_pkg::NUM_REGS];
	scalar_types_pkg::address_t model_pc;
	scalar_types_pkg::reg_index_t model_dst;
	scalar_types_pkg::data_t model_value;
	bit model_ok;
	scalar_types_pkg::data_t last_value;
	bit have_write;
	bit checking;
	bit term_seen;
	bit aborted;
	int write_index;
	int error_count;

	scalar_unit DUT (
		.clock(clock),
		.reset(reset),
		.run(run),
		.store_req(store_req),
		.store(store),
		.store_ack(store_ack),
		.result(result),
		.status(status),
		.term(term)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	////////////////////////////////////////
	// Reporting
	////////////////////////////////////////

	task automatic report_mismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual);
		error_count++;
	endtask

	task automatic report_failure(input string what);
		$display("[ERROR] %0t %s", $time, what);
		error_count++;
	endtask

	task automatic finish_run();
		$display("Errors: %0d", error_count);
		if (error_count == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	endtask

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////

	// Steps the stored program up to its next register write
	function automatic bit model_step(output scalar_types_pkg::reg_index_t dst,
		output scalar_types_pkg::data_t value);
		scalar_isa_pkg::instr_t word;
		scalar_types_pkg::data_t a;
		scalar_types_pkg::data_t b;
		dst = '0;
		value = '0;
		for (int n = 0; n < scalar_types_pkg::INSTR_DEPTH; n++) begin
			word = model_mem[model_pc];
			if (word.op == scalar_isa_pkg::op_end) begin
				return 1'b0;
			end
			model_pc++;
			a = model_regs[word.src1];
			b = model_regs[word.src2];
			dst = word.dst;
			case (word.op)
				scalar_isa_pkg::op_add: value = a + b;
				scalar_isa_pkg::op_sub: value = a - b;
				scalar_isa_pkg::op_and: value = a & b;
				scalar_isa_pkg::op_or: value = a | b;
				scalar_isa_pkg::op_xor: value = a ^ b;
				scalar_isa_pkg::op_shl: value = a << b[4:0];
				scalar_isa_pkg::op_shr: value = a >> b[4:0];
				scalar_isa_pkg::op_ldi: value = {{16{word.imm[15]}}, word.imm};
				default: continue;
			endcase
			model_regs[dst] = value;
			return 1'b1;
		end
		return 1'b0;
	endfunction

	////////////////////////////////////////
	// Stimulus file and stores
	////////////////////////////////////////

	task automatic load_stim();
		int fd;
		int code;
		string line;
		logic [31:0] f_addr, f_op, f_dst, f_src1, f_src2, f_imm;
		scalar_isa_pkg::instr_t word;
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			report_failure("cannot open the stimulus file");
			aborted = 1'b1;
		end else begin
			while (!$feof(fd)) begin
				code = $fgets(line, fd);
				if (code > 0 && line.len() > 0 && line[0] == "P") begin
					code = $sscanf(line, "P %h %h %h %h %h %h",
						f_addr, f_op, f_dst, f_src1, f_src2, f_imm);
					word.op = scalar_isa_pkg::opcode_t'(f_op[3:0]);
					word.dst = scalar_types_pkg::reg_index_t'(f_dst);
					word.src1 = scalar_types_pkg::reg_index_t'(f_src1);
					word.src2 = scalar_types_pkg::reg_index_t'(f_src2);
					word.imm = scalar_types_pkg::imm_t'(f_imm);
					prog_addr.push_back(scalar_types_pkg::address_t'(f_addr));
					prog_word.push_back(word);
					model_mem[scalar_types_pkg::address_t'(f_addr)] = word;
				end else if (code > 0 && line.len() > 0 && line[0] == "W") begin
					code = $sscanf(line, "W %h %h", f_dst, f_imm);
					exp_dst.push_back(scalar_types_pkg::reg_index_t'(f_dst));
					exp_data.push_back(f_imm);
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic store_word(input scalar_types_pkg::address_t address,
		input scalar_isa_pkg::instr_t word);
		int cycles;
		@(posedge clock);
		store_req <= 1'b1;
		store.address <= address;
		store.instr <= word;
		@(posedge clock);
		store_req <= 1'b0;
		cycles = 1;
		@(negedge clock);
		while (!store_ack && cycles < STORE_TIMEOUT) begin
			@(negedge clock);
			cycles++;
		end
		if (!store_ack) begin
			report_failure("no store_ack arrived after a store request");
			aborted = 1'b1;
		end else begin
			assert (cycles == 1) else report_mismatch("store_ack latency", 1, 32'(cycles));
			// Single pulse
			@(negedge clock);
			assert (!store_ack) else report_mismatch("store_ack", 0, 32'(store_ack));
		end
	endtask

	////////////////////////////////////////
	// Reset and run phases
	////////////////////////////////////////

	task automatic apply_reset();
		checking = 1'b0;
		reset <= 1'b1;
		run <= 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		assert (!result.valid) else report_mismatch("result.valid", 0, 32'(result.valid));
		assert (!store_ack) else report_mismatch("store_ack", 0, 32'(store_ack));
		assert (!term) else report_mismatch("term", 0, 32'(term));
		assert (status == '0) else report_mismatch("status", 0, 32'(status));
	endtask

	// Random gaps drop run for about a quarter of the cycles
	task automatic run_program(input bit gaps);
		int cycles;
		write_index = 0;
		have_write = 1'b0;
		term_seen = 1'b0;
		last_value = '0;
		model_pc = '0;
		foreach (model_regs[i]) model_regs[i] = '0;
		checking = 1'b1;
		cycles = 0;
		while (!term_seen && cycles < RUN_TIMEOUT) begin
			@(posedge clock);
			run <= gaps ? ($urandom_range(3) != 0) : 1'b1;
			cycles++;
		end
		if (!term_seen) begin
			report_failure("term did not rise before the timeout");
			aborted = 1'b1;
		end else begin
			// Watch for results after termination
			repeat (TAIL_CYCLES) begin
				@(posedge clock);
				run <= 1'b1;
			end
			@(negedge clock);
			assert (write_index == exp_dst.size())
				else report_mismatch("result count", 32'(exp_dst.size()), 32'(write_index));
			@(posedge clock);
			run <= 1'b0;
			checking = 1'b0;
		end
	endtask

	////////////////////////////////////////
	// Output monitor
	////////////////////////////////////////

	always @(negedge clock) begin
		if (checking) begin
			assert (!(result.valid && !run)) else report_failure("result.valid high with run low");
			// Status follows the write of the previous cycle
			if (have_write) begin
				assert (status.zero == (last_value == '0))
					else report_mismatch("status.zero", 32'(last_value == '0), 32'(status.zero));
				assert (status.negative == last_value[31])
					else report_mismatch("status.negative", 32'(last_value[31]),
						32'(status.negative));
			end
			// term rises in the cycle after the last result and then holds
			if (term_seen) begin
				assert (term) else report_failure("term not held high after the last result");
			end else if (term || write_index == exp_dst.size()) begin
				term_seen = 1'b1;
				assert (term) else report_failure("term missing in the cycle after the last result");
				assert (write_index == exp_dst.size())
					else report_mismatch("results before term", 32'(exp_dst.size()),
						32'(write_index));
			end
			if (result.valid) begin
				assert (write_index < exp_dst.size()) else report_failure("extra result appeared");
				if (write_index < exp_dst.size()) begin
					assert (result.dst == exp_dst[write_index])
						else report_mismatch("result.dst", 32'(exp_dst[write_index]),
							32'(result.dst));
					assert (result.data == exp_data[write_index])
						else report_mismatch("result.data", exp_data[write_index], result.data);
					// Model value drives the status expectation
					model_ok = model_step(model_dst, model_value);
					assert (model_ok)
						else report_failure("program has no write left for this result");
					assert (model_value == exp_data[write_index])
						else report_mismatch("model data", exp_data[write_index], model_value);
					assert (model_dst == exp_dst[write_index])
						else report_mismatch("model dst", 32'(exp_dst[write_index]),
							32'(model_dst));
					last_value = model_value;
					have_write = 1'b1;
					write_index++;
				end
			end
		end
	end

	initial begin
		reset = 1'b1;
		run = 1'b0;
		store_req = 1'b0;
		store = '0;
		error_count = 0;
		checking = 1'b0;
		aborted = 1'b0;
		void'($urandom(RANDOM_SEED));
		load_stim();
		if (!aborted) begin
			apply_reset();
			foreach (prog_addr[i]) begin
				if (!aborted) begin
					store_word(prog_addr[i], prog_word[i]);
				end
			end
		end
		if (!aborted) begin
			run_program(1'b0);
		end
		if (!aborted) begin
			apply_reset();
			run_program(1'b1);
		end
		finish_run();
	end

endmodule

// File: sim/scalar_stim.txt
# P address opcode dst src1 src2 imm, all hex; opcodes 0 nop 1 add 2 sub 3 and 4 or 5 xor
# 6 shl 7 shr 8 ldi 9 end; W dst data lists the expected writes in program order
P 00 8 01 00 00 0005
P 01 8 02 00 00 FFFD
P 02 1 03 01 02 0000
P 03 8 04 00 00 7FFF
P 04 6 05 04 04 0000
P 05 1 06 05 05 0000
P 06 2 07 06 01 0000
P 07 3 08 07 04 0000
P 08 4 09 08 02 0000
P 09 5 0A 09 08 0000
P 0A 8 0B 00 00 0024
P 0B 7 0C 0A 0B 0000
P 0C 0 00 00 00 0000
P 0D 2 0D 0C 03 0000
P 0E 9 00 00 00 0000
P 0F 8 0E 00 00 1234
P 10 1 0F 01 01 0000
W 01 00000005
W 02 FFFFFFFD
W 03 00000002
W 04 00007FFF
W 05 80000000
W 06 00000000
W 07 FFFFFFFB
W 08 00007FFB
W 09 FFFFFFFF
W 0A FFFF8004
W 0B 00000024
W 0C 0FFFF800
W 0D 0FFFF7FE

// File: build.f
source/scalar_types_pkg.sv
source/scalar_isa_pkg.sv
source/instr_mem.sv
source/scalar_decode.sv
source/register_file.sv
source/scalar_execute.sv
source/scalar_result.sv
source/scalar_unit.sv
sim/scalar_unit_properties.sv
sim/scalar_unit_tb.sv

// File: Makefile
# Verilator build and run of the scalar unit testbench
VERILATOR ?= verilator
TOP ?= scalar_unit_tb
FILE_LIST ?= build.f
BUILD_DIR ?= obj_dir
VERILATOR_FLAGS ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Verification passed

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
